// File: hdl/nabp_pkg.sv
package nabp_pkg;

    // projection line geometry
    localparam int line_size = 32;
    localparam int s_width = 5;

    // sample widths
    localparam int raw_width = 16;
    localparam int filtered_width = 16;

    typedef logic [raw_width-1:0] raw_t;
    typedef logic signed [filtered_width-1:0] filtered_t;
    typedef logic [s_width-1:0] s_t;

    // ramp filter
    localparam int fir_order = 4;
    localparam int tap_width = 4;

    typedef logic signed [tap_width-1:0] tap_t;

    // weights for offsets -2 to +2 around the centre sample
    localparam tap_t fir_taps [fir_order + 1] = '{
        tap_t'(-1),
        tap_t'(-2),
        tap_t'(6),
        tap_t'(-2),
        tap_t'(-1)
    };

    // accumulator wide enough for the full five-tap sum
    localparam int acc_width = raw_width + tap_width + 4;

    // registered read of the line buffer
    localparam int ram_latency = 1;

    // cycles spent priming the filter before the first write
    localparam int fill_lead = fir_order / 2 + ram_latency;

    typedef enum logic [1:0] {
        ready,
        delay,
        fill
    } fill_state_t;

endpackage

// File: hdl/dual_port_ram.sv
module dual_port_ram #(
    parameter type word_t = nabp_pkg::raw_t
) (
    input  logic         clk,
    // read-write port
    input  logic         we_0,
    input  nabp_pkg::s_t addr_0,
    input  word_t        data_in_0,
    output word_t        data_out_0,
    // read-only port
    input  nabp_pkg::s_t addr_1,
    output word_t        data_out_1
);

    // one projection line of words
    word_t mem [nabp_pkg::line_size];

    always_ff @(posedge clk)
    begin
        if (we_0)
        begin
            mem[addr_0] <= data_in_0;
        end
    end

    // both read ports registered, old data on a port 0 write
    always_ff @(posedge clk)
    begin
        data_out_0 <= mem[addr_0];
    end

    always_ff @(posedge clk)
    begin
        data_out_1 <= mem[addr_1];
    end

endmodule

// File: hdl/ramp_filter.sv
module ramp_filter (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  nabp_pkg::raw_t      sample_in,
    output nabp_pkg::filtered_t sample_out
);

    // earlier samples, history[0] is the most recent one
    nabp_pkg::raw_t history [nabp_pkg::fir_order];

    // current sample plus history, window[k] sits at offset +2-k
    nabp_pkg::raw_t window [nabp_pkg::fir_order + 1];

    logic signed [nabp_pkg::acc_width-1:0] acc;

    // flush held one cycle longer, the line buffer still returns
    // the word addressed during the clear
    logic clear_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            clear_q <= 1'b1;
        else
            clear_q <= clear;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || clear || clear_q)
        begin
            for (int k = 0; k < nabp_pkg::fir_order; k++)
                history[k] <= '0;
        end
        else
        begin
            history[0] <= sample_in;
            for (int k = 1; k < nabp_pkg::fir_order; k++)
                history[k] <= history[k-1];
        end
    end

    always_comb
    begin
        window[0] = sample_in;
        for (int k = 1; k <= nabp_pkg::fir_order; k++)
            window[k] = history[k-1];
    end

    // raw samples are unsigned, zero-extend before the signed product
    always_comb
    begin
        acc = '0;
        for (int k = 0; k <= nabp_pkg::fir_order; k++)
        begin
            acc = acc + nabp_pkg::fir_taps[nabp_pkg::fir_order - k]
                      * $signed({1'b0, window[k]});
        end
    end

    // truncate to the filtered sample width
    assign sample_out = acc[nabp_pkg::filtered_width-1:0];

endmodule

// File: hdl/filtered_ram_fill.sv
module filtered_ram_fill (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                fill_kick,
    input  nabp_pkg::filtered_t hs_val,
    input  nabp_pkg::s_t        pr0_s,
    input  nabp_pkg::s_t        pr1_s,
    output logic                fill_done,
    output nabp_pkg::s_t        hs_s,
    output logic                filter_clear,
    output logic                busy,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    localparam nabp_pkg::s_t last_s = nabp_pkg::s_t'(nabp_pkg::line_size - 1);
    localparam nabp_pkg::s_t lead_s = nabp_pkg::s_t'(nabp_pkg::fill_lead - 1);

    nabp_pkg::fill_state_t state;
    nabp_pkg::fill_state_t next_state;

    nabp_pkg::s_t read_itr;
    nabp_pkg::s_t write_itr;
    nabp_pkg::s_t addr_0;

    logic delay_done;
    logic last_write;
    logic write_enable;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::ready;
        else
            state <= next_state;
    end

    assign delay_done = (read_itr == lead_s);
    assign last_write = (write_itr == last_s);

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready:
                if (fill_kick)
                    next_state = nabp_pkg::delay;
            nabp_pkg::delay:
                if (delay_done)
                    next_state = nabp_pkg::fill;
            nabp_pkg::fill:
                if (last_write)
                    next_state = nabp_pkg::ready;
            default:
                next_state = nabp_pkg::ready;
        endcase
    end

    // read side runs fill_lead words ahead of the write side
    always_ff @(posedge clk)
    begin
        if (!reset_n || state == nabp_pkg::ready)
        begin
            read_itr <= '0;
            write_itr <= '0;
        end
        else if (state == nabp_pkg::delay)
        begin
            read_itr <= read_itr + 1'b1;
        end
        else if (!last_write)
        begin
            write_itr <= write_itr + 1'b1;
            // stop at the last sample so the tail repeats it
            if (read_itr != last_s)
                read_itr <= read_itr + 1'b1;
        end
    end

    assign write_enable = (state == nabp_pkg::fill);
    assign fill_done = write_enable && (next_state == nabp_pkg::ready);
    assign hs_s = read_itr;
    assign filter_clear = (state == nabp_pkg::ready);
    assign busy = (state != nabp_pkg::ready);

    // writer owns port 0 for the whole fill
    assign addr_0 = busy ? write_itr : pr0_s;

    dual_port_ram #(
        .word_t(nabp_pkg::filtered_t)
    ) u_filtered_ram (
        .clk        (clk),
        .we_0       (write_enable),
        .addr_0     (addr_0),
        .data_in_0  (hs_val),
        .data_out_0 (pr0_val),
        .addr_1     (pr1_s),
        .data_out_1 (pr1_val)
    );

endmodule

// File: hdl/filtered_ram_swap.sv
module filtered_ram_swap (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                fill_kick,
    input  logic                swap,
    input  nabp_pkg::filtered_t hs_val,
    input  nabp_pkg::s_t        pr0_s,
    input  nabp_pkg::s_t        pr1_s,
    output logic                fill_done,
    output nabp_pkg::s_t        hs_s,
    output logic                filter_clear,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    // bank_sel names the fill bank, the other one is read
    logic bank_sel;
    logic read_sel_q;

    logic [1:0] bank_kick;
    logic [1:0] bank_done;
    logic [1:0] bank_clear;
    logic [1:0] bank_busy;

    nabp_pkg::s_t bank_hs_s [2];
    nabp_pkg::filtered_t bank_pr0_val [2];
    nabp_pkg::filtered_t bank_pr1_val [2];

    // no swap while a fill runs or is being started
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            bank_sel <= 1'b0;
        else if (swap && bank_busy == 2'b00 && !fill_kick)
            bank_sel <= ~bank_sel;
    end

    // follows the reader address by one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            read_sel_q <= 1'b1;
        else
            read_sel_q <= ~bank_sel;
    end

    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        assign bank_kick[b] = fill_kick && (bank_sel == 1'(b));

        filtered_ram_fill u_fill (
            .clk          (clk),
            .reset_n      (reset_n),
            .fill_kick    (bank_kick[b]),
            .hs_val       (hs_val),
            .pr0_s        (pr0_s),
            .pr1_s        (pr1_s),
            .fill_done    (bank_done[b]),
            .hs_s         (bank_hs_s[b]),
            .filter_clear (bank_clear[b]),
            .busy         (bank_busy[b]),
            .pr0_val      (bank_pr0_val[b]),
            .pr1_val      (bank_pr1_val[b])
        );
    end

    // fill side
    assign hs_s = bank_hs_s[bank_sel];
    assign filter_clear = bank_clear[bank_sel];
    assign fill_done = bank_done[bank_sel];

    // read side
    assign pr0_val = bank_pr0_val[read_sel_q];
    assign pr1_val = bank_pr1_val[read_sel_q];

endmodule

// File: hdl/filter_subsystem_top.sv
module filter_subsystem_top (
    input  logic                clk,
    input  logic                reset_n,
    // raw line load
    input  logic                load_en,
    input  nabp_pkg::s_t        load_addr,
    input  nabp_pkg::raw_t      load_data,
    // fill control
    input  logic                fill_kick,
    input  logic                swap,
    output logic                fill_done,
    // processing readers
    input  nabp_pkg::s_t        pr0_s,
    input  nabp_pkg::s_t        pr1_s,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    nabp_pkg::s_t hs_s;
    nabp_pkg::raw_t sample_in;
    nabp_pkg::filtered_t hs_val;
    logic filter_clear;

    // raw line buffer, host writes on port 0, fill reads on port 1
    dual_port_ram #(
        .word_t(nabp_pkg::raw_t)
    ) u_line_buffer (
        .clk        (clk),
        .we_0       (load_en),
        .addr_0     (load_addr),
        .data_in_0  (load_data),
        .data_out_0 (),
        .addr_1     (hs_s),
        .data_out_1 (sample_in)
    );

    ramp_filter u_ramp_filter (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear      (filter_clear),
        .sample_in  (sample_in),
        .sample_out (hs_val)
    );

    filtered_ram_swap u_banks (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .swap         (swap),
        .hs_val       (hs_val),
        .pr0_s        (pr0_s),
        .pr1_s        (pr1_s),
        .fill_done    (fill_done),
        .hs_s         (hs_s),
        .filter_clear (filter_clear),
        .pr0_val      (pr0_val),
        .pr1_val      (pr1_val)
    );

endmodule

// File: bench/filter_tb.sv
module filter_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rows = 7;
    localparam int fill_cycles = 35;
    localparam int cycle_limit = num_rows * (32 + 36 + 70 + 10);

    // line patterns
    localparam int pat_ramp = 0;
    localparam int pat_impulse = 1;
    localparam int pat_const = 2;
    localparam int pat_random = 3;

    logic clk;
    logic reset_n;
    logic load_en;
    nabp_pkg::s_t load_addr;
    nabp_pkg::raw_t load_data;
    logic fill_kick;
    logic swap;
    logic fill_done;
    nabp_pkg::s_t pr0_s;
    nabp_pkg::s_t pr1_s;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    // stimulus table, one row per test
    string row_name [num_rows] = '{"ramp", "impulse_5", "impulse_0", "impulse_31",
                                   "constant", "strobes", "random"};
    int row_pattern [num_rows] = '{pat_ramp, pat_impulse, pat_impulse, pat_impulse,
                                   pat_const, pat_random, pat_random};
    // impulse index or constant value
    int row_arg [num_rows] = '{0, 5, 0, 31, 'h1234, 0, 0};
    // second kick and a swap in the middle of the fill
    bit row_strobes [num_rows] = '{0, 0, 0, 0, 0, 1, 0};
    // swap between the fill and the read phase
    bit row_swap_before [num_rows] = '{1, 1, 1, 1, 1, 0, 1};
    int row_readable [num_rows] = '{0, 1, 0, 1, 0, 0, 1};

    nabp_pkg::raw_t raw_line [nabp_pkg::line_size];
    nabp_pkg::filtered_t bank_model [2][nabp_pkg::line_size];
    bit bank_known [2];
    int fill_bank;
    int cycle_count;
    int errors;
    int checks;
    int tests_failed;

    filter_subsystem_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fill_kick (fill_kick),
        .swap      (swap),
        .pr0_s     (pr0_s),
        .pr1_s     (pr1_s),
        .fill_done (fill_done),
        .pr0_val   (pr0_val),
        .pr1_val   (pr1_val)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout, run stopped after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic make_line(input int pattern, input int arg);
        for (int i = 0; i < nabp_pkg::line_size; i++)
        begin
            case (pattern)
                pat_ramp:    raw_line[i] = nabp_pkg::raw_t'(i * 2000 + 7);
                pat_impulse: raw_line[i] = (i == arg) ? 16'h0100 : 16'h0000;
                pat_const:   raw_line[i] = nabp_pkg::raw_t'(arg);
                default:     raw_line[i] = nabp_pkg::raw_t'($urandom);
            endcase
        end
    endtask

    // zero before index 0, last sample repeated past the end
    task automatic filter_reference(input int bank);
        int acc;
        int pos;
        int x;
        for (int s = 0; s < nabp_pkg::line_size; s++)
        begin
            acc = 0;
            for (int t = 0; t <= nabp_pkg::fir_order; t++)
            begin
                pos = s + t - nabp_pkg::fir_order / 2;
                if (pos < 0)
                    x = 0;
                else if (pos >= nabp_pkg::line_size)
                    x = int'(raw_line[nabp_pkg::line_size - 1]);
                else
                    x = int'(raw_line[pos]);
                acc = acc + int'(nabp_pkg::fir_taps[t]) * x;
            end
            bank_model[bank][s] = nabp_pkg::filtered_t'(acc);
        end
        bank_known[bank] = 1'b1;
    endtask

    task automatic compare_word(input string test_name, input string what, input int idx,
                                input nabp_pkg::filtered_t expected,
                                input nabp_pkg::filtered_t actual);
        checks++;
        assert (expected == actual)
        else
        begin
            $display("ERR %s %s[%0d] expected %h actual %h",
                     test_name, what, idx, expected, actual);
            errors++;
        end
    endtask

    task automatic load_line();
        for (int i = 0; i < nabp_pkg::line_size; i++)
        begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= nabp_pkg::s_t'(i);
            load_data <= raw_line[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // kick a fill, watch fill_done and read the other bank meanwhile
    task automatic run_fill(input int r);
        int done_cycle;
        int done_count;
        int old_bank;
        bit check_old;
        done_cycle = -1;
        done_count = 0;
        old_bank = 1 - fill_bank;
        check_old = bank_known[old_bank];
        for (int k = 0; k <= fill_cycles + 5; k++)
        begin
            @(posedge clk);
            fill_kick <= (k == 0) || (row_strobes[r] && k == fill_cycles / 2);
            swap <= row_strobes[r] && (k == fill_cycles / 2 + 3);
            pr0_s <= nabp_pkg::s_t'(k);
            pr1_s <= nabp_pkg::s_t'(nabp_pkg::line_size - 1 - k);
            @(negedge clk);
            if (fill_done)
            begin
                done_count++;
                if (done_cycle < 0)
                    done_cycle = k;
            end
            if (check_old && k > 0 && k <= nabp_pkg::line_size)
            begin
                compare_word(row_name[r], "old pr0", k - 1,
                             bank_model[old_bank][k - 1], pr0_val);
                compare_word(row_name[r], "old pr1", nabp_pkg::line_size - k,
                             bank_model[old_bank][nabp_pkg::line_size - k], pr1_val);
            end
        end
        checks++;
        assert (done_cycle == fill_cycles)
        else
        begin
            $display("ERR %s fill_done cycle expected %0d actual %0d",
                     row_name[r], fill_cycles, done_cycle);
            errors++;
        end
        checks++;
        assert (done_count == 1)
        else
        begin
            $display("%s: fill_done pulsed %0d times instead of once", row_name[r], done_count);
            errors++;
        end
        filter_reference(fill_bank);
    endtask

    // only issued while idle, so the swap always takes effect
    task automatic pulse_swap();
        @(posedge clk);
        swap <= 1'b1;
        @(posedge clk);
        swap <= 1'b0;
        @(posedge clk);
        fill_bank = 1 - fill_bank;
    endtask

    task automatic read_bank(input int r, input int bank);
        for (int k = 0; k <= nabp_pkg::line_size; k++)
        begin
            @(posedge clk);
            pr0_s <= nabp_pkg::s_t'(k);
            pr1_s <= nabp_pkg::s_t'(nabp_pkg::line_size - 1 - k);
            @(negedge clk);
            if (k > 0)
            begin
                compare_word(row_name[r], "pr0", k - 1, bank_model[bank][k - 1], pr0_val);
                compare_word(row_name[r], "pr1", nabp_pkg::line_size - k,
                             bank_model[bank][nabp_pkg::line_size - k], pr1_val);
            end
        end
    endtask

    initial
    begin
        int start_errors;
        int readable;
        void'($urandom(32'h735b8cd6));
        clk = 1'b0;
        reset_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        fill_kick = 1'b0;
        swap = 1'b0;
        pr0_s = '0;
        pr1_s = '0;
        cycle_count = 0;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        fill_bank = 0;
        bank_known[0] = 1'b0;
        bank_known[1] = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        for (int r = 0; r < num_rows; r++)
        begin
            start_errors = errors;
            make_line(row_pattern[r], row_arg[r]);
            load_line();
            run_fill(r);
            if (row_swap_before[r])
                pulse_swap();
            // the DUT must present the bank the table names
            readable = row_readable[r];
            read_bank(r, readable);
            if (errors != start_errors)
                tests_failed++;
            $display("test %-10s bank %0d  %0d errors", row_name[r], readable,
                     errors - start_errors);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_rows, tests_failed, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: list.f
hdl/nabp_pkg.sv
hdl/dual_port_ram.sv
hdl/ramp_filter.sv
hdl/filtered_ram_fill.sv
hdl/filtered_ram_swap.sv
hdl/filter_subsystem_top.sv
bench/filter_tb.sv

// File: Makefile
# Verilator build and run of the filter subsystem testbench

VERILATOR ?= verilator
TOP       ?= filter_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
